//--- design/xbar_cfg_pkg.sv
// Single fixed configuration; the slave index prefix assumes a power-of-two slave port count
package xbar_cfg_pkg;

  // Port and map sizes
  localparam int unsigned NUM_SLV_PORTS = 2;
  localparam int unsigned NUM_MST_PORTS = 2;
  localparam int unsigned NUM_RULES     = 3;

  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned SLV_ID_W  = 3;
  localparam int unsigned SLV_IDX_W = 1;                     // Enough for NUM_SLV_PORTS
  localparam int unsigned MST_ID_W  = SLV_ID_W + SLV_IDX_W;  // Slave index prepended
  localparam int unsigned LEN_W     = 4;                     // Burst has len + 1 beats
  localparam int unsigned RESP_W    = 2;

  // One extra target for the decode error slave
  localparam int unsigned MST_SEL_W = $clog2(NUM_MST_PORTS + 1);

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [SLV_ID_W-1:0]  slv_id_t;
  typedef logic [MST_ID_W-1:0]  mst_id_t;
  typedef logic [LEN_W-1:0]     len_t;
  typedef logic [RESP_W-1:0]    resp_t;
  typedef logic [MST_SEL_W-1:0] mst_sel_t;  // NUM_MST_PORTS selects the error slave
  typedef logic [SLV_IDX_W-1:0] slv_idx_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  // Address range [start_addr, end_addr) mapped to one master port
  typedef struct packed {
    mst_sel_t mst_idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } addr_rule_t;

endpackage

//--- design/axi_rd_pkg.sv
// AR and R channel bundles only; no user, cache, prot or burst type fields are carried
package axi_rd_pkg;

  import xbar_cfg_pkg::*;

  // AR channel, slave side
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_ar_t;

  // AR channel, master side with extended ID
  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ar_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } slv_r_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } mst_r_t;

  // Request and response bundles, slave side
  typedef struct packed {
    slv_ar_t ar;
    logic    ar_valid;
    logic    r_ready;
  } slv_req_t;

  typedef struct packed {
    logic   ar_ready;
    slv_r_t r;
    logic   r_valid;
  } slv_resp_t;

  // Same bundles toward the master ports
  typedef struct packed {
    mst_ar_t ar;
    logic    ar_valid;
    logic    r_ready;
  } mst_req_t;

  typedef struct packed {
    logic   ar_ready;
    mst_r_t r;
    logic   r_valid;
  } mst_resp_t;

endpackage

//--- design/rd_addr_decode.sv
// Purely combinational; overlapping rules resolve to the lowest rule index and no default port
`timescale 1ns/1ps

module rd_addr_decode
  import xbar_cfg_pkg::*;
(
  input  addr_t                       addr_i,
  input  addr_rule_t [NUM_RULES-1:0]  addr_map_i,
  output mst_sel_t                    sel_o
);

  logic [NUM_RULES-1:0] hit;  // Per-rule range match

  always_comb begin
    for (int unsigned i = 0; i < NUM_RULES; i++) begin
      hit[i] = (addr_i >= addr_map_i[i].start_addr) &&
               (addr_i <  addr_map_i[i].end_addr);
    end
  end

  // First matching rule wins
  always_comb begin
    logic found;
    found = 1'b0;
    sel_o = mst_sel_t'(NUM_MST_PORTS);  // No match goes to the error slave
    for (int unsigned i = 0; i < NUM_RULES; i++) begin
      if (!found && hit[i]) begin
        sel_o = addr_map_i[i].mst_idx;
        found = 1'b1;
      end
    end
  end

endmodule

//--- design/rd_demux.sv
// One outstanding read per slave port; sel_i must stay stable while the AR waits for ready
`timescale 1ns/1ps

module rd_demux
  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  slv_req_t                      slv_req_i,
  output slv_resp_t                     slv_resp_o,
  input  mst_sel_t                      sel_i,
  output slv_req_t  [NUM_MST_PORTS:0]   mst_reqs_o,   // Last entry is the error slave
  input  slv_resp_t [NUM_MST_PORTS:0]   mst_resps_i
);

  typedef enum logic {
    DMX_IDLE,
    DMX_BUSY
  } dmx_state_e;

  dmx_state_e state_q;
  mst_sel_t   tgt_q;     // Target of the read in flight
  logic       ar_fire;
  logic       r_done;

  assign ar_fire = slv_req_i.ar_valid && slv_resp_o.ar_ready;
  assign r_done  = slv_resp_o.r_valid && slv_req_i.r_ready && slv_resp_o.r.last;

  // Request fan-out
  always_comb begin
    for (int unsigned i = 0; i <= NUM_MST_PORTS; i++) begin
      mst_reqs_o[i].ar       = slv_req_i.ar;  // Payload broadcast, valid selects
      mst_reqs_o[i].ar_valid = (state_q == DMX_IDLE) && slv_req_i.ar_valid &&
                               (sel_i == mst_sel_t'(i));
      mst_reqs_o[i].r_ready  = (state_q == DMX_BUSY) && slv_req_i.r_ready &&
                               (tgt_q == mst_sel_t'(i));
    end
  end

  // Response selection
  always_comb begin
    slv_resp_o.ar_ready = 1'b0;
    if (state_q == DMX_IDLE) begin
      slv_resp_o.ar_ready = mst_resps_i[sel_i].ar_ready;
    end
    slv_resp_o.r       = mst_resps_i[tgt_q].r;
    slv_resp_o.r_valid = (state_q == DMX_BUSY) && mst_resps_i[tgt_q].r_valid;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= DMX_IDLE;
      tgt_q   <= '0;
    end else begin
      case (state_q)
        DMX_IDLE: begin
          if (ar_fire) begin
            state_q <= DMX_BUSY;
            tgt_q   <= sel_i;      // Hold route until the last beat
          end
        end
        DMX_BUSY: begin
          if (r_done) state_q <= DMX_IDLE;
        end
        default: state_q <= DMX_IDLE;
      endcase
    end
  end

  // A stalled AR must keep its payload, or the route could change mid-handshake
  ar_payload_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (slv_req_i.ar_valid && !slv_resp_o.ar_ready) |=> $stable(slv_req_i.ar)
  ) else $error("AR payload changed while waiting for ready");

endmodule

//--- design/rd_err_slv.sv
// Accepts one burst at a time and answers with DECERR and zero data for every beat
`timescale 1ns/1ps

module rd_err_slv
  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  slv_req_t  req_i,
  output slv_resp_t resp_o
);

  typedef enum logic {
    ERR_IDLE,
    ERR_BURST
  } err_state_e;

  err_state_e state_q;
  slv_id_t    id_q;    // ID echoed on every beat
  len_t       cnt_q;   // Beats left after the current one

  assign resp_o.ar_ready = (state_q == ERR_IDLE);
  assign resp_o.r_valid  = (state_q == ERR_BURST);
  assign resp_o.r.id     = id_q;
  assign resp_o.r.data   = '0;
  assign resp_o.r.resp   = RESP_DECERR;
  assign resp_o.r.last   = (cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ERR_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ERR_IDLE: begin
          if (req_i.ar_valid) begin
            state_q <= ERR_BURST;
            cnt_q   <= req_i.ar.len;
          end
        end
        ERR_BURST: begin
          if (req_i.r_ready) begin
            if (resp_o.r.last) state_q <= ERR_IDLE;
            else               cnt_q   <= cnt_q - 1'b1;
          end
        end
        default: state_q <= ERR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ERR_IDLE && req_i.ar_valid) id_q <= req_i.ar.id;
  end

  // After the final beat the slave sits idle with no beat pending
  no_beat_in_idle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (resp_o.r_valid && req_i.r_ready && resp_o.r.last) |=> !resp_o.r_valid
  ) else $error("Error slave drives r_valid while idle");

endmodule

//--- design/rd_mux.sv
// Round-robin AR arbitration; R routing trusts the top ID bits returned by the downstream slave
`timescale 1ns/1ps

module rd_mux
  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  slv_req_t  [NUM_SLV_PORTS-1:0]    slv_reqs_i,
  output slv_resp_t [NUM_SLV_PORTS-1:0]    slv_resps_o,
  output mst_req_t                         mst_req_o,
  input  mst_resp_t                        mst_resp_i
);

  slv_idx_t prio_q;   // Port checked first when no grant is held
  slv_idx_t gnt_q;    // Grant kept while its AR is stalled
  logic     lock_q;
  slv_idx_t gnt;
  slv_idx_t r_idx;    // Slave port owning the current R beat

  // Round-robin pick starting at prio_q
  always_comb begin
    slv_idx_t cand;
    logic     found;
    found = 1'b0;
    gnt   = prio_q;
    for (int unsigned i = 0; i < NUM_SLV_PORTS; i++) begin
      cand = slv_idx_t'(prio_q + i);
      if (!found && slv_reqs_i[cand].ar_valid) begin
        gnt   = cand;
        found = 1'b1;
      end
    end
    if (lock_q) gnt = gnt_q;
  end

  // AR toward the master port, ID prefixed with the slave index
  always_comb begin
    mst_req_o.ar.id   = {gnt, slv_reqs_i[gnt].ar.id};
    mst_req_o.ar.addr = slv_reqs_i[gnt].ar.addr;
    mst_req_o.ar.len  = slv_reqs_i[gnt].ar.len;
    mst_req_o.ar_valid = slv_reqs_i[gnt].ar_valid;
  end

  assign r_idx = mst_resp_i.r.id[MST_ID_W-1 -: SLV_IDX_W];
  assign mst_req_o.r_ready = slv_reqs_i[r_idx].r_ready;

  always_comb begin
    for (int unsigned s = 0; s < NUM_SLV_PORTS; s++) begin
      slv_resps_o[s].ar_ready = (gnt == slv_idx_t'(s)) && mst_resp_i.ar_ready;
      slv_resps_o[s].r.id     = mst_resp_i.r.id[SLV_ID_W-1:0];  // Prefix stripped
      slv_resps_o[s].r.data   = mst_resp_i.r.data;
      slv_resps_o[s].r.resp   = mst_resp_i.r.resp;
      slv_resps_o[s].r.last   = mst_resp_i.r.last;
      slv_resps_o[s].r_valid  = mst_resp_i.r_valid && (r_idx == slv_idx_t'(s));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else if (mst_req_o.ar_valid) begin
      if (mst_resp_i.ar_ready) begin
        lock_q <= 1'b0;
        prio_q <= slv_idx_t'(gnt + 1'b1);  // Move past the winner
      end else begin
        lock_q <= 1'b1;
        gnt_q  <= gnt;
      end
    end
  end

  // A stalled AR keeps its grant, so the downstream payload cannot switch ports
  grant_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (mst_req_o.ar_valid && !mst_resp_i.ar_ready) |=> (gnt == $past(gnt))
  ) else $error("Grant moved while the granted AR was stalled");

endmodule

//--- design/rd_xbar.sv
// Read-only crossbar with combinational paths; each slave port has at most one read in flight
`timescale 1ns/1ps

module rd_xbar
  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  slv_req_t   [NUM_SLV_PORTS-1:0]     slv_req_i,
  output slv_resp_t  [NUM_SLV_PORTS-1:0]     slv_resp_o,
  output mst_req_t   [NUM_MST_PORTS-1:0]     mst_req_o,
  input  mst_resp_t  [NUM_MST_PORTS-1:0]     mst_resp_i,
  input  addr_rule_t [NUM_RULES-1:0]         addr_map_i
);

  // Demux side, one extra entry per port for the error slave
  slv_req_t  [NUM_SLV_PORTS-1:0][NUM_MST_PORTS:0]   dmx_reqs;
  slv_resp_t [NUM_SLV_PORTS-1:0][NUM_MST_PORTS:0]   dmx_resps;

  // Mux side, still slave-side types since the mux extends the ID
  slv_req_t  [NUM_MST_PORTS-1:0][NUM_SLV_PORTS-1:0] mux_reqs;
  slv_resp_t [NUM_MST_PORTS-1:0][NUM_SLV_PORTS-1:0] mux_resps;

  for (genvar s = 0; s < NUM_SLV_PORTS; s++) begin : gen_slv_port
    mst_sel_t ar_sel;

    rd_addr_decode u_decode (
      .addr_i     (slv_req_i[s].ar.addr),
      .addr_map_i (addr_map_i),
      .sel_o      (ar_sel)
    );

    rd_demux u_demux (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .slv_req_i   (slv_req_i[s]),
      .slv_resp_o  (slv_resp_o[s]),
      .sel_i       (ar_sel),
      .mst_reqs_o  (dmx_reqs[s]),
      .mst_resps_i (dmx_resps[s])
    );

    rd_err_slv u_err_slv (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (dmx_reqs[s][NUM_MST_PORTS]),
      .resp_o  (dmx_resps[s][NUM_MST_PORTS])
    );
  end

  // Cross wiring
  for (genvar s = 0; s < NUM_SLV_PORTS; s++) begin : gen_cross_slv
    for (genvar m = 0; m < NUM_MST_PORTS; m++) begin : gen_cross_mst
      assign mux_reqs[m][s]  = dmx_reqs[s][m];
      assign dmx_resps[s][m] = mux_resps[m][s];
    end
  end

  for (genvar m = 0; m < NUM_MST_PORTS; m++) begin : gen_mst_port
    rd_mux u_mux (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .slv_reqs_i  (mux_reqs[m]),
      .slv_resps_o (mux_resps[m]),
      .mst_req_o   (mst_req_o[m]),
      .mst_resp_i  (mst_resp_i[m])
    );
  end

endmodule

//--- sim/tb_rd_checks.svh
// Included inside the testbench module, which must import xbar_cfg_pkg before this point
`ifndef TB_RD_CHECKS_SVH
`define TB_RD_CHECKS_SVH

int unsigned data_errs   = 0;
int unsigned resp_errs   = 0;
int unsigned id_errs     = 0;
int unsigned mst_id_errs = 0;
int unsigned last_errs   = 0;
int unsigned other_errs  = 0;  // Protocol and ordering problems

task automatic check_data(input string name, input data_t exp, input data_t act);
  if (act !== exp) begin
    data_errs++;
    $display("ERROR %s: expected 0x%h, actual 0x%h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_resp(input string name, input resp_t exp, input resp_t act);
  if (act !== exp) begin
    resp_errs++;
    $display("ERROR %s: expected 0x%h, actual 0x%h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_id(input string name, input slv_id_t exp, input slv_id_t act);
  if (act !== exp) begin
    id_errs++;
    $display("ERROR %s: expected 0x%h, actual 0x%h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_mst_id(input string name, input mst_id_t exp, input mst_id_t act);
  if (act !== exp) begin
    mst_id_errs++;
    $display("ERROR %s: expected 0x%h, actual 0x%h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_last(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    last_errs++;
    $display("ERROR %s: expected 0x%h, actual 0x%h at %0t", name, exp, act, $time);
  end
endtask

task automatic flag_problem(input string msg);
  other_errs++;
  $display("Problem at %0t: %s", $time, msg);
endtask

function automatic int unsigned total_errors();
  return data_errs + resp_errs + id_errs + mst_id_errs + last_errs + other_errs;
endfunction

`endif

//--- sim/tb_rd_xbar.sv
// Fixed map with rule 2 overlapping rule 1 and a hole above 0x3000_0000; 200 reads per port
`timescale 1ns/1ps

module tb_rd_xbar
  import xbar_cfg_pkg::*;
  import axi_rd_pkg::*;
();

  localparam int unsigned NUM_READS  = 200;
  localparam int unsigned TIMEOUT_NS = NUM_READS * NUM_SLV_PORTS * (16 + 16) * 4 * 4;
  localparam data_t       DATA_KEY   = 32'h5A5A0000;
  localparam mst_sel_t    ERR_TGT    = mst_sel_t'(NUM_MST_PORTS);

  logic clk;
  logic rst_n;
  slv_req_t   [NUM_SLV_PORTS-1:0] slv_req;
  slv_resp_t  [NUM_SLV_PORTS-1:0] slv_resp;
  mst_req_t   [NUM_MST_PORTS-1:0] mst_req;
  mst_resp_t  [NUM_MST_PORTS-1:0] mst_resp;
  addr_rule_t [NUM_RULES-1:0]     addr_map;

  logic [31:0] rng_state;
  logic        busy     [NUM_SLV_PORTS];  // One expected read per slave port
  slv_ar_t     exp_ar   [NUM_SLV_PORTS];
  mst_sel_t    exp_tgt  [NUM_SLV_PORTS];
  mst_sel_t    pend_tgt [NUM_SLV_PORTS];  // Target of the AR on offer
  int unsigned beat_cnt [NUM_SLV_PORTS];
  int unsigned issued   [NUM_SLV_PORTS];
  int unsigned done_cnt [NUM_SLV_PORTS];
  int unsigned passed   [NUM_SLV_PORTS];  // Turns lost while waiting for a grant
  mst_ar_t     ar_q     [NUM_MST_PORTS][$];
  int unsigned rsp_beat [NUM_MST_PORTS];

  `include "tb_rd_checks.svh"

  always #2 clk = ~clk;

  rd_xbar u_rd_xbar (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp),
    .addr_map_i (addr_map)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Beat k of a burst as the responders build it; the error slave gives zero
  function automatic data_t beat_data(input addr_t addr, input int unsigned k,
                                      input mst_sel_t tgt);
    if (tgt == ERR_TGT) return '0;
    return data_t'(addr + addr_t'(4 * k)) ^ data_t'(DATA_KEY * tgt);
  endfunction

  // Region 0 hits rule 0, 1 hits rule 1 first, 2 only rule 2, 3 the hole
  function automatic void pick_read(output slv_ar_t ar, output mst_sel_t tgt);
    logic [31:0] r;
    r       = next_rand();
    ar.id   = slv_id_t'(r[2:0]);
    ar.len  = len_t'(r[6:3]);
    r       = next_rand();
    ar.addr = {(r[29:28] == 2'd3) ? 4'hA : {2'b00, r[29:28]}, r[27:2], 2'b00};
    tgt     = (r[29:28] == 2'd1) ? mst_sel_t'(1) :
              (r[29:28] == 2'd3) ? ERR_TGT : mst_sel_t'(0);
  endfunction

  always @(posedge clk) begin : per_cycle
    mst_ar_t                  ar_m;
    slv_ar_t                  ar_s;
    mst_sel_t                 tgt;
    logic [31:0]              r;
    logic                     hit;
    logic [NUM_SLV_PORTS-1:0] waiting;  // AR offered to a mux by an idle demux, not yet taken
    if (rst_n) begin
      for (int s = 0; s < NUM_SLV_PORTS; s++) begin
        waiting[s] = !busy[s] && slv_req[s].ar_valid && !slv_resp[s].ar_ready;
      end
      // A master-side AR must match a slave AR accepted in the same cycle
      for (int m = 0; m < NUM_MST_PORTS; m++) begin
        if (mst_req[m].ar_valid && mst_resp[m].ar_ready) begin
          ar_m = mst_req[m].ar;
          hit  = 1'b0;
          for (int s = 0; s < NUM_SLV_PORTS; s++) begin
            if (slv_req[s].ar_valid && slv_resp[s].ar_ready &&
                pend_tgt[s] == mst_sel_t'(m)) begin
              hit = 1'b1;
              check_mst_id($sformatf("mst%0d arid", m), {slv_idx_t'(s), slv_req[s].ar.id},
                           ar_m.id);
            end
          end
          if (!hit) flag_problem($sformatf("master port %0d got an AR no slave port sent", m));
          ar_q[m].push_back(ar_m);
        end
      end
      for (int s = 0; s < NUM_SLV_PORTS; s++) begin
        if (slv_req[s].ar_valid && slv_resp[s].ar_ready) begin
          if (busy[s]) flag_problem($sformatf("slave port %0d took an AR mid-read", s));
          hit = (pend_tgt[s] == ERR_TGT) ||
                (mst_req[pend_tgt[s]].ar_valid && mst_resp[pend_tgt[s]].ar_ready);
          if (!hit) flag_problem($sformatf("read of slave port %0d missed its master", s));
          for (int o = 0; o < NUM_SLV_PORTS; o++) begin
            if (o != s && waiting[o] &&
                pend_tgt[o] == pend_tgt[s] && pend_tgt[s] != ERR_TGT) begin
              passed[o]++;
              if (passed[o] > 1) flag_problem($sformatf("slave port %0d passed over twice", o));
            end
          end
          busy[s]     = 1'b1;
          exp_ar[s]   = slv_req[s].ar;
          exp_tgt[s]  = pend_tgt[s];
          beat_cnt[s] = 0;
        end
        if (slv_resp[s].r_valid && slv_req[s].r_ready) begin
          if (!busy[s]) begin
            flag_problem($sformatf("slave port %0d got an R beat with no read in flight", s));
          end else begin
            tgt = exp_tgt[s];
            check_data($sformatf("slv%0d rdata", s),
                       beat_data(exp_ar[s].addr, beat_cnt[s], tgt), slv_resp[s].r.data);
            check_resp($sformatf("slv%0d rresp", s),
                       (tgt == ERR_TGT) ? RESP_DECERR : RESP_OKAY, slv_resp[s].r.resp);
            check_id($sformatf("slv%0d rid", s), exp_ar[s].id, slv_resp[s].r.id);
            check_last($sformatf("slv%0d rlast", s), beat_cnt[s] == exp_ar[s].len,
                       slv_resp[s].r.last);
            if (beat_cnt[s] == exp_ar[s].len) begin
              busy[s] = 1'b0;
              done_cnt[s]++;
            end else begin
              beat_cnt[s]++;
            end
          end
        end
      end
      // Responders answer in order, holding each beat until ready
      for (int m = 0; m < NUM_MST_PORTS; m++) begin
        hit = mst_resp[m].r_valid && !mst_req[m].r_ready;
        if (mst_resp[m].r_valid && mst_req[m].r_ready) begin
          if (mst_resp[m].r.last) begin
            void'(ar_q[m].pop_front());
            rsp_beat[m] = 0;
          end else begin
            rsp_beat[m]++;
          end
        end
        r = next_rand();
        mst_resp[m].ar_ready <= r[0];
        if (!hit) begin
          if (ar_q[m].size() != 0 && r[2:1] != 2'd0) begin
            mst_resp[m].r.id    <= ar_q[m][0].id;  // Extended ID echoed
            mst_resp[m].r.data  <= beat_data(ar_q[m][0].addr, rsp_beat[m], mst_sel_t'(m));
            mst_resp[m].r.resp  <= RESP_OKAY;
            mst_resp[m].r.last  <= (rsp_beat[m] == ar_q[m][0].len);
            mst_resp[m].r_valid <= 1'b1;
          end else begin
            mst_resp[m].r_valid <= 1'b0;
          end
        end
      end
      for (int s = 0; s < NUM_SLV_PORTS; s++) begin
        r = next_rand();
        slv_req[s].r_ready <= (r[1:0] != 2'd0);
        if (!(slv_req[s].ar_valid && !slv_resp[s].ar_ready)) begin
          if (issued[s] < NUM_READS && r[3:2] == 2'd0) begin
            pick_read(ar_s, tgt);
            slv_req[s].ar       <= ar_s;
            slv_req[s].ar_valid <= 1'b1;
            pend_tgt[s] = tgt;
            passed[s]   = 0;
            issued[s]++;
          end else begin
            slv_req[s].ar_valid <= 1'b0;
          end
        end
      end
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    rng_state   = 32'he8d94859;
    slv_req     = '0;
    mst_resp    = '0;
    addr_map[0] = '{mst_idx: mst_sel_t'(0), start_addr: 32'h0000_0000, end_addr: 32'h1000_0000};
    addr_map[1] = '{mst_idx: mst_sel_t'(1), start_addr: 32'h1000_0000, end_addr: 32'h2000_0000};
    addr_map[2] = '{mst_idx: mst_sel_t'(0), start_addr: 32'h1800_0000, end_addr: 32'h3000_0000};
    for (int i = 0; i < NUM_SLV_PORTS; i++) begin
      busy[i]     = 1'b0;
      issued[i]   = 0;
      done_cnt[i] = 0;
      passed[i]   = 0;
    end
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      rsp_beat[i] = 0;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    wait (done_cnt[0] == NUM_READS && done_cnt[1] == NUM_READS);
    repeat (8) @(posedge clk);
    for (int m = 0; m < NUM_MST_PORTS; m++) begin
      if (ar_q[m].size() != 0) flag_problem($sformatf("master port %0d left reads open", m));
    end
    $display("Errors: data %0d, resp %0d, id %0d, mst_id %0d, last %0d, other %0d",
             data_errs, resp_errs, id_errs, mst_id_errs, last_errs, other_errs);
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog sized for full-length bursts with long gaps
  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out after %0d ns before all reads completed", TIMEOUT_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- tb.f
+incdir+sim
design/xbar_cfg_pkg.sv
design/axi_rd_pkg.sv
design/rd_addr_decode.sv
design/rd_demux.sv
design/rd_err_slv.sv
design/rd_mux.sv
design/rd_xbar.sv
sim/tb_rd_xbar.sv
